// ==== pdp8_mem.f ====
design/pdp8_mem_pkg.sv
design/core_ram.sv
design/mem_arbiter.sv
design/mem_address_unit.sv
design/major_cycle_ctrl.sv
design/disk_break_channel.sv
design/pdp8_mem_top.sv
dv/pdp8_mem_tb.sv

// ==== Makefile ====
# Verilator build and run for the PDP-8 memory subsystem

SIM = obj_dir/pdp8_mem_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module pdp8_mem_tb -f pdp8_mem.f -o pdp8_mem_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/pdp8_mem_tb.sv ====
module pdp8_mem_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import pdp8_mem_pkg::*;

  logic clk = 1'b0;
  logic reset, start, sw, addr_load, deposit, examine, go, to_disk;
  word_t sr, ac, go_count, disk2mem, mdout, instruction, ma, mem2disk;
  field_t if_field, df_field;
  eaddr_t go_addr;
  logic operand_valid, run, instr_done, disk_rd, mem2disk_valid, dma_done;

  word_t ref_mem [0:32767];  // model of the 32K core
  word_t disk_buf [0:15];
  int exp_ops[$];
  int disk_idx, out_base, out_idx, done_cnt, ifld, dfld, pbase, plen;
  int instr_cnt, exp_instr;

  pdp8_mem_top #(.MEM_AWIDTH(15)) dut0 (.*);

  always #50 clk = ~clk;

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(int got, int exp, string what);
    if (got != exp) begin
      $display("CHECK FAILED at %0t ns: %s got %0o expected %0o", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  // compare side: operands and outgoing disk words
  always @(negedge clk) begin
    if (operand_valid) begin
      if (exp_ops.size() == 0) fail_now("operand strobe while no operand was expected");
      else check(int'(mdout), exp_ops.pop_front(), "operand");
    end
    if (mem2disk_valid) begin
      check(int'(mem2disk), int'(ref_mem[(out_base + out_idx) & 32'h7fff]), "mem2disk");
      out_idx++;
    end
    if (dma_done) done_cnt++;
    if (instr_done) instr_cnt++;
    if (disk_rd) begin
      @(posedge clk);
      #1;
      disk_idx++;
      disk2mem = disk_buf[disk_idx & 15];
    end
  end

  task automatic wait_h1();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > 200) fail_now("timeout waiting for the halt loop");
    end while (dut0.u_ctrl.state != H1);
  endtask

  task automatic load_addr(int fld, int addr);
    wait_h1();
    if_field = field_t'(fld);
    sr = word_t'(addr);
    addr_load = 1'b1;
    @(posedge clk);
    #1 addr_load = 1'b0;
  endtask

  // panel deposit from the model, or examine against it
  task automatic panel_range(int fld, int addr, int n, bit wr);
    int a;
    load_addr(fld, addr);
    for (int i = 0; i < n; i++) begin
      a = (addr + i) & 12'o7777;
      wait_h1();
      check(int'(ma), a, "ma step");
      if (wr) begin
        sr = ref_mem[fld * 4096 + a];
        deposit = 1'b1;
      end else begin
        check(int'(mdout), int'(ref_mem[fld * 4096 + a]), "examine");
        examine = 1'b1;
      end
      @(posedge clk);
      #1;
      deposit = 1'b0;
      examine = 1'b0;
      if (wr) check(int'(mdout), int'(sr), "deposit echo");
    end
  endtask

  task automatic all_regions(bit wr);
    panel_range(ifld, pbase, plen, wr);
    panel_range(ifld, 8'o10, 8'o70, wr);  // pointers then direct data
    panel_range(ifld, pbase + 8'o100, 8'o40, wr);
    panel_range(dfld, 12'o4000, 8'o100, wr);
  endtask

  function automatic word_t rand_word();
    return ($urandom % 4 == 0) ? 12'o7777 : word_t'($urandom);
  endfunction

  // straight-line program with forward jumps only, ends in two halts
  function automatic void gen_program(bit ind);
    int op, t, w;
    for (int i = 0; i < plen - 2; i++) begin
      op = int'($urandom % 6);
      if (op < 4) begin
        if (ind && $urandom % 2 == 1) w = (op << 9) | 12'o0400 | (8 + int'($urandom % 24));
        else if ($urandom % 2 == 1) w = (op << 9) | 8'o40 + int'($urandom % 32);
        else w = (op << 9) | 12'o0200 | (8'o100 + int'($urandom % 32));
      end else begin
        t = i + 1 + int'($urandom % 3);
        if (t > plen - 6 + op) t = plen - 6 + op;  // JMS keeps room for X+1
        w = (op << 9) | 12'o0200 | t;
      end
      ref_mem[ifld * 4096 + pbase + i] = word_t'(w);
    end
    ref_mem[ifld * 4096 + pbase + plen - 2] = HLT_WORD;
    ref_mem[ifld * 4096 + pbase + plen - 1] = HLT_WORD;
    for (int a = 8; a < 8'o40; a++) ref_mem[ifld * 4096 + a] = word_t'(12'o4000 + $urandom % 32);
    for (int a = 8'o40; a < 8'o100; a++) ref_mem[ifld * 4096 + a] = rand_word();
    for (int a = 0; a < 8'o40; a++) ref_mem[ifld * 4096 + pbase + 8'o100 + a] = rand_word();
    for (int a = 0; a < 8'o100; a++) ref_mem[dfld * 4096 + 12'o4000 + a] = rand_word();
  endfunction

  // interprets the memory-reference subset, returns pc after the halt
  function automatic int run_ref(int pc);
    int w, op, ea, fld, x, d, here;
    for (int step = 0; step < 1000; step++) begin
      exp_instr++;
      here = pc;
      w = int'(ref_mem[ifld * 4096 + pc]);
      pc = (pc + 1) & 12'o7777;
      op = w >> 9;
      if (op >= 6) begin
        if (w == 12'o7402) return pc;
        continue;
      end
      ea = ((w & 12'o0200) != 0 ? (here & 12'o7600) : 0) | (w & 8'o177);
      if ((w & 12'o0400) != 0 && op < 5) begin
        d = int'(ref_mem[ifld * 4096 + ea]);
        if (ea >= 8 && ea <= 8'o17) begin  // auto-index
          d = (d + 1) & 12'o7777;
          ref_mem[ifld * 4096 + ea] = word_t'(d);
        end
        ea = d;
      end
      if (op == 5) begin
        pc = ea;
        continue;
      end
      fld = ((w & 12'o0400) != 0 && op < 4) ? dfld : ifld;
      x = fld * 4096 + ea;
      d = int'(ref_mem[x]);
      case (op)
        0, 1: exp_ops.push_back(d);
        2: begin
          ref_mem[x] = word_t'((d + 1) & 12'o7777);
          if (d == 12'o7777) pc = (pc + 1) & 12'o7777;
        end
        3: ref_mem[x] = ac;
        default: begin
          ref_mem[x] = word_t'(pc);
          pc = (ea + 1) & 12'o7777;
        end
      endcase
    end
    return -1;
  endfunction

  task automatic run_program(bit ind, bit with_disk);
    int n, exp_pc;
    pbase = 12'o200 * (2 + int'($urandom % 12));
    plen = 12 + int'($urandom % 9);
    ac = word_t'($urandom);
    gen_program(ind);
    all_regions(1'b1);
    exp_instr = 0;
    exp_pc = run_ref(pbase);
    df_field = field_t'(dfld);
    load_addr(ifld, pbase);
    wait_h1();
    instr_cnt = 0;
    start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    if (with_disk) begin
      go = 1'b1;
      @(posedge clk);
      #1 go = 1'b0;
    end
    n = 0;
    while (run) begin
      @(posedge clk);
      #1 n++;
      if (n > 5000) fail_now("timeout waiting for the program to halt");
    end
    check(int'(dut0.u_ctrl.pc), exp_pc, "final pc");
    check(exp_ops.size(), 0, "operands left over");
    check(instr_cnt, exp_instr, "instructions done");
  endtask

  task automatic wait_done(int cnt);
    int n;
    n = 0;
    while (done_cnt < cnt) begin
      @(posedge clk);
      #1 n++;
      if (n > 2000) fail_now("timeout waiting for dma_done");
    end
  endtask

  initial begin
    void'($urandom(32'h7851b76a));
    {reset, start, sw, addr_load, deposit, examine, go, to_disk} = 8'h80;
    {sr, ac, go_count, disk2mem} = '0;
    {if_field, df_field} = '0;
    go_addr = '0;
    {disk_idx, out_base, out_idx, done_cnt} = '0;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    check(int'({run, instr_done, operand_valid, disk_rd, mem2disk_valid, dma_done}), 0, "strobes");
    check(int'(instruction), 12'o7000, "instruction after reset");
    check(int'(ma), 0, "ma after reset");

    ifld = 3;
    for (int k = 0; k < 4; k++) begin
      pbase = int'($urandom % 4096);
      for (int i = 0; i < 4; i++) ref_mem[ifld * 4096 + ((pbase + i) & 12'o7777)] = rand_word();
      panel_range(ifld, pbase, 4, 1'b1);
      panel_range(ifld, pbase, 4, 1'b0);
    end

    for (int p = 0; p < 3; p++) begin
      ifld = p;
      dfld = p;
      run_program(1'b0, 1'b0);
      all_regions(1'b0);
    end

    ifld = 1;
    dfld = 4;
    repeat (2) begin
      run_program(1'b1, 1'b0);
      all_regions(1'b0);
    end

    // disk block crosses from field 5 into field 6
    for (int i = 0; i < 16; i++) begin
      disk_buf[i] = word_t'($urandom);
      ref_mem[(5 * 4096 + 12'o7770 + i) & 32'h7fff] = disk_buf[i];
    end
    disk2mem = disk_buf[0];
    go_addr = eaddr_t'(5 * 4096 + 12'o7770);
    go_count = 12'd16;
    to_disk = 1'b0;
    dfld = 2;
    run_program(1'b1, 1'b1);
    wait_done(1);
    check(disk_idx, 16, "disk words taken");
    all_regions(1'b0);
    panel_range(5, 12'o7770, 8, 1'b0);
    panel_range(6, 0, 8, 1'b0);

    out_base = 2 * 4096 + 12'o4000;
    go_addr = eaddr_t'(out_base);
    to_disk = 1'b1;
    wait_h1();
    go = 1'b1;
    @(posedge clk);
    #1 go = 1'b0;
    wait_done(2);
    repeat (20) @(posedge clk);
    check(out_idx, 16, "mem2disk words");
    check(done_cnt, 2, "dma_done pulses");

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== design/pdp8_mem_top.sv ====
module pdp8_mem_top #(
  parameter int MEM_AWIDTH = 15
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  pdp8_mem_pkg::word_t  sr,
  input  logic                 sw,
  input  logic                 addr_load,
  input  logic                 deposit,
  input  logic                 examine,
  input  pdp8_mem_pkg::field_t if_field,
  input  pdp8_mem_pkg::field_t df_field,
  input  pdp8_mem_pkg::word_t  ac,
  input  logic                 go,
  input  pdp8_mem_pkg::eaddr_t go_addr,
  input  pdp8_mem_pkg::word_t  go_count,
  input  logic                 to_disk,
  input  pdp8_mem_pkg::word_t  disk2mem,
  output pdp8_mem_pkg::word_t  mdout,
  output logic                 operand_valid,
  output pdp8_mem_pkg::word_t  instruction,
  output pdp8_mem_pkg::word_t  ma,
  output logic                 run,
  output logic                 instr_done,
  output logic                 disk_rd,
  output pdp8_mem_pkg::word_t  mem2disk,
  output logic                 mem2disk_valid,
  output logic                 dma_done
);
  import pdp8_mem_pkg::*;

  major_state_e state;
  word_t        pc;
  word_t        ram_rdata;
  word_t        rdata;
  mem_req_t     cpu_req;
  mem_req_t     dma_req_bus;
  mem_req_t     ram_req;
  logic         cpu_rvalid;
  logic         dma_rvalid;
  logic         isz_skip;
  logic         break_req;

  core_ram #(.MEM_AWIDTH(MEM_AWIDTH)) u_ram (
    .clk(clk), .req(ram_req), .rdata(ram_rdata)
  );

  mem_arbiter #(.MEM_AWIDTH(MEM_AWIDTH)) u_arb (
    .clk(clk), .reset(reset), .state(state), .cpu_req(cpu_req), .dma_req(dma_req_bus),
    .ram_req(ram_req), .ram_rdata(ram_rdata), .rdata(rdata),
    .cpu_rvalid(cpu_rvalid), .dma_rvalid(dma_rvalid)
  );

  mem_address_unit u_mau (
    .clk(clk), .reset(reset), .state(state), .pc(pc), .ac(ac), .sr(sr),
    .if_field(if_field), .df_field(df_field), .sw(sw), .addr_load(addr_load),
    .deposit(deposit), .examine(examine), .rdata(rdata), .cpu_rvalid(cpu_rvalid),
    .cpu_req(cpu_req), .ma(ma), .mdout(mdout), .instruction(instruction),
    .isz_skip(isz_skip)
  );

  major_cycle_ctrl u_ctrl (
    .clk(clk), .reset(reset), .start(start), .sr(sr), .addr_load(addr_load),
    .break_req(break_req), .instruction(instruction), .ma(ma), .mdout(mdout),
    .isz_skip(isz_skip), .state(state), .pc(pc), .run(run),
    .instr_done(instr_done), .operand_valid(operand_valid)
  );

  disk_break_channel u_disk (
    .clk(clk), .reset(reset), .state(state), .go(go), .go_addr(go_addr),
    .go_count(go_count), .to_disk(to_disk), .disk2mem(disk2mem), .rdata(rdata),
    .dma_rvalid(dma_rvalid), .dma_req(dma_req_bus), .break_req(break_req),
    .disk_rd(disk_rd), .mem2disk_valid(mem2disk_valid), .dma_done(dma_done),
    .mem2disk(mem2disk)
  );

endmodule

// ==== design/disk_break_channel.sv ====
module disk_break_channel (
  input  logic                       clk,
  input  logic                       reset,
  input  pdp8_mem_pkg::major_state_e state,
  input  logic                       go,
  input  pdp8_mem_pkg::eaddr_t       go_addr,
  input  pdp8_mem_pkg::word_t        go_count,
  input  logic                       to_disk,
  input  pdp8_mem_pkg::word_t        disk2mem,
  input  pdp8_mem_pkg::word_t        rdata,
  input  logic                       dma_rvalid,
  output pdp8_mem_pkg::mem_req_t     dma_req,
  output logic                       break_req,
  output logic                       disk_rd,
  output logic                       mem2disk_valid,
  output logic                       dma_done,
  output pdp8_mem_pkg::word_t        mem2disk
);
  import pdp8_mem_pkg::*;

  eaddr_t cur_addr;
  word_t  count;  // words left, 0 means 4096
  logic   dir;    // high for memory to disk
  logic   busy;
  logic   last;

  assign last = (count == 12'o0001);
  assign break_req = busy;
  assign disk_rd = (state == DB0) && busy && !dir;  // disk hands over one word

  always_comb begin
    dma_req = '0;
    dma_req.addr = cur_addr;
    dma_req.wdata = disk2mem;
    if (state == DB0 && busy) begin
      dma_req.valid = 1'b1;
      dma_req.write = !dir;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      dma_done <= 1'b0;
      mem2disk_valid <= 1'b0;
    end else begin
      if (go && !busy) busy <= 1'b1;
      else if (state == DB1 && last) busy <= 1'b0;  // no further break after this one
      dma_done <= (state == DB2) && last;
      mem2disk_valid <= dma_rvalid;
    end
  end

  always_ff @(posedge clk) begin
    if (go && !busy) begin
      cur_addr <= go_addr;
      count <= go_count;
      dir <= to_disk;
    end else if (state == DB2) begin
      cur_addr <= cur_addr + 15'd1;  // wraps in the 15-bit space
      count <= count - 12'o0001;
    end
    if (dma_rvalid) mem2disk <= rdata;
  end

endmodule

// ==== design/major_cycle_ctrl.sv ====
module major_cycle_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  pdp8_mem_pkg::word_t        sr,
  input  logic                       addr_load,
  input  logic                       break_req,
  input  pdp8_mem_pkg::word_t        instruction,
  input  pdp8_mem_pkg::word_t        ma,
  input  pdp8_mem_pkg::word_t        mdout,
  input  logic                       isz_skip,
  output pdp8_mem_pkg::major_state_e state,
  output pdp8_mem_pkg::word_t        pc,
  output logic                       run,
  output logic                       instr_done,
  output logic                       operand_valid
);
  import pdp8_mem_pkg::*;

  logic [0:2]   opcode;
  logic         defer;
  logic         halt_word;
  major_state_e resume;  // where to go between instructions
  major_state_e next_state;

  assign opcode = instruction[0:2];
  assign defer = instruction[3] && (opcode < JMP);
  assign halt_word = (mdout == HLT_WORD);  // fetched word is still in mdout at F3
  assign resume = break_req ? DB0 : (run ? F0 : H0);

  always_comb begin
    case (state)
      F0: next_state = FW;
      FW: next_state = F1;
      F1: next_state = F2;
      F2: next_state = F3;
      F3: begin
        if (opcode >= IOT) next_state = halt_word ? H0 : resume;
        else next_state = defer ? D0 : E0;
      end
      D0: next_state = DW;
      DW: next_state = D1;
      D1: next_state = D2;
      D2: next_state = E0;
      E0: next_state = EW;
      EW: next_state = (opcode == JMP) ? resume : E1;
      E1: next_state = E2;
      E2: next_state = E3;
      H0: next_state = HW;
      HW: next_state = H1;
      H1: next_state = H2;
      H2: next_state = H3;
      DB0: next_state = DB1;
      DB1: next_state = DB2;
      default: next_state = resume;  // E3, H3, DB2
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= H0;
      pc <= '0;
      run <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        FW: pc <= pc + 12'o0001;
        F3: if (opcode >= IOT && halt_word) run <= 1'b0;
        EW: if (opcode == JMP) pc <= ma;
        E3: begin
          if (opcode == JMS) pc <= ma + 12'o0001;
          else if (isz_skip) pc <= pc + 12'o0001;
        end
        H1, H2: begin
          if (start) run <= 1'b1;
          if (addr_load) pc <= sr;
        end
        default: pc <= pc;
      endcase
    end
  end

  always_comb begin
    case (state)
      F3: instr_done = (opcode >= IOT);
      EW: instr_done = (opcode == JMP);
      E3: instr_done = 1'b1;
      default: instr_done = 1'b0;
    endcase
  end

  assign operand_valid = (state == E2) && ((opcode == AND) || (opcode == TAD));

endmodule

// ==== design/mem_address_unit.sv ====
module mem_address_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  pdp8_mem_pkg::major_state_e state,
  input  pdp8_mem_pkg::word_t        pc,
  input  pdp8_mem_pkg::word_t        ac,
  input  pdp8_mem_pkg::word_t        sr,
  input  pdp8_mem_pkg::field_t       if_field,
  input  pdp8_mem_pkg::field_t       df_field,
  input  logic                       sw,
  input  logic                       addr_load,
  input  logic                       deposit,
  input  logic                       examine,
  input  pdp8_mem_pkg::word_t        rdata,
  input  logic                       cpu_rvalid,
  output pdp8_mem_pkg::mem_req_t     cpu_req,
  output pdp8_mem_pkg::word_t        ma,
  output pdp8_mem_pkg::word_t        mdout,
  output pdp8_mem_pkg::word_t        instruction,
  output logic                       isz_skip
);
  import pdp8_mem_pkg::*;

  logic [0:2] opcode;
  logic       data_ind;    // operand sits in the data field
  logic       auto_index;  // pointer in 0010..0017
  logic       panel;
  eaddr_t     eaddr;

  assign opcode = instruction[0:2];
  assign data_ind = instruction[3] && (opcode < JMS);
  assign auto_index = (ma[0:8] == 9'o001);
  assign panel = (state == H1) || (state == H2);

  always_comb begin
    case (state)
      F0, FW: eaddr = {if_field, pc};
      E0, EW, E1, E2, E3: eaddr = data_ind ? {df_field, ma} : {if_field, ma};
      default: eaddr = {if_field, ma};
    endcase
  end

  // reads in the first state of each cycle, writes are issued combinationally
  always_comb begin
    cpu_req = '0;
    cpu_req.addr = eaddr;
    case (state)
      F0, D0, E0, H0: cpu_req.valid = 1'b1;
      D1: begin
        if (auto_index) begin
          cpu_req.valid = 1'b1;
          cpu_req.write = 1'b1;
          cpu_req.wdata = mdout + 12'o0001;
        end
      end
      E1: begin
        case (opcode)
          ISZ: cpu_req.wdata = mdout + 12'o0001;
          DCA: cpu_req.wdata = ac;
          JMS: cpu_req.wdata = pc;  // return address, already stepped
          default: cpu_req.wdata = '0;
        endcase
        cpu_req.valid = (opcode == ISZ) || (opcode == DCA) || (opcode == JMS);
        cpu_req.write = cpu_req.valid;
      end
      H1, H2: begin
        if (deposit && !addr_load) begin
          cpu_req.valid = 1'b1;
          cpu_req.write = 1'b1;
          cpu_req.wdata = sr;
        end
      end
      default: cpu_req.valid = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ma <= '0;
      instruction <= 12'o7000;
      isz_skip <= 1'b0;
    end else begin
      if (state == FW && cpu_rvalid) instruction <= rdata;
      case (state)
        F0: ma <= pc;  // keeps the page of the instruction
        F3: begin
          if (opcode < IOT) begin
            ma <= {instruction[4] ? ma[0:4] : 5'b00000, instruction[5:11]};
          end
        end
        D2: ma <= auto_index ? mdout + 12'o0001 : mdout;
        E1: if (opcode == ISZ && mdout == 12'o7777) isz_skip <= 1'b1;
        E3: isz_skip <= 1'b0;
        H1, H2: begin
          if (addr_load) ma <= sw ? 12'o7777 : sr;
          else if (deposit || examine) ma <= ma + 12'o0001;
        end
        default: ma <= ma;
      endcase
    end
  end

  // memory buffer
  always_ff @(posedge clk) begin
    if (cpu_rvalid) mdout <= rdata;
    else if (panel && deposit && !addr_load) mdout <= sr;  // show what was stored
  end

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter #(
  parameter int MEM_AWIDTH = 15
) (
  input  logic                         clk,
  input  logic                         reset,
  input  pdp8_mem_pkg::major_state_e   state,
  input  pdp8_mem_pkg::mem_req_t       cpu_req,
  input  pdp8_mem_pkg::mem_req_t       dma_req,
  output pdp8_mem_pkg::mem_req_t       ram_req,
  input  pdp8_mem_pkg::word_t          ram_rdata,
  output pdp8_mem_pkg::word_t          rdata,
  output logic                         cpu_rvalid,
  output logic                         dma_rvalid
);
  import pdp8_mem_pkg::*;

  localparam eaddr_t ADDR_MASK = eaddr_t'((32'd1 << MEM_AWIDTH) - 32'd1);

  logic     dma_owner;
  logic     rd_pend;  // a read went out last cycle
  logic     rd_dma;   // ... and it belonged to the channel
  mem_req_t sel_req;

  // break cycles belong to the disk channel
  assign dma_owner = state inside {DB0, DB1, DB2};

  always_comb begin
    sel_req = dma_owner ? dma_req : cpu_req;
    ram_req = sel_req;
    ram_req.addr = sel_req.addr & ADDR_MASK;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend <= 1'b0;
      rd_dma <= 1'b0;
    end else begin
      rd_pend <= ram_req.valid && !ram_req.write;
      rd_dma <= dma_owner;
    end
  end

  assign rdata = ram_rdata;
  assign cpu_rvalid = rd_pend && !rd_dma;
  assign dma_rvalid = rd_pend && rd_dma;

endmodule

// ==== design/core_ram.sv ====
module core_ram #(
  parameter int MEM_AWIDTH = 15
) (
  input  logic                clk,
  input  pdp8_mem_pkg::mem_req_t req,
  output pdp8_mem_pkg::word_t    rdata
);
  import pdp8_mem_pkg::*;

  localparam int ADDR_LO = 15 - MEM_AWIDTH;

  word_t mem [0:(1 << MEM_AWIDTH) - 1];
  logic [MEM_AWIDTH-1:0] index;

  assign index = req.addr[ADDR_LO:14];  // low bits of the extended address

  always_ff @(posedge clk) begin
    if (req.valid) begin
      if (req.write) mem[index] <= req.wdata;
      else rdata <= mem[index];  // valid in the following state
    end
  end

endmodule

// ==== design/pdp8_mem_pkg.sv ====
package pdp8_mem_pkg;

  // bit 0 is the msb, as on the PDP-8
  typedef logic [0:11] word_t;
  typedef logic [0:2]  field_t;
  typedef logic [0:14] eaddr_t;  // field then 12-bit address

  typedef enum logic [4:0] {
    F0, FW, F1, F2, F3,
    D0, DW, D1, D2,
    E0, EW, E1, E2, E3,
    H0, HW, H1, H2, H3,
    DB0, DB1, DB2
  } major_state_e;

  // opcodes in instruction[0:2]
  localparam logic [0:2] AND = 3'o0;
  localparam logic [0:2] TAD = 3'o1;
  localparam logic [0:2] ISZ = 3'o2;
  localparam logic [0:2] DCA = 3'o3;
  localparam logic [0:2] JMS = 3'o4;
  localparam logic [0:2] JMP = 3'o5;
  localparam logic [0:2] IOT = 3'o6;
  localparam logic [0:2] OPR = 3'o7;

  localparam word_t HLT_WORD = 12'o7402;  // group 2 operate, halt bit only

  // one RAM access, read when write is low
  typedef struct packed {
    logic   valid;
    logic   write;
    eaddr_t addr;
    word_t  wdata;
  } mem_req_t;

endpackage
